// ==== src/dispatch_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// widths, depths and packed layouts shared by the dispatch stage
// count types are sized for the depths below; change them together
// rs_type codes other than rs_type_int take a ROB slot only
//////////////////////////////////////////////////////////////////////
package dispatch_pkg;

    localparam int dispatch_rate = 2;   // uops per rename group
    localparam int rob_depth     = 16;
    localparam int rs_int_depth  = 8;
    localparam int prf_depth     = 32;

    //////////////////////////////////////////////////////////////////////
    // vector types

    typedef logic [$clog2(prf_depth)-1:0]    preg_t;     // physical register number
    typedef logic [$clog2(rob_depth)-1:0]    rob_idx_t;
    typedef logic [$clog2(rob_depth):0]      rob_cnt_t;  // 0 to rob_depth
    typedef logic [$clog2(rs_int_depth):0]   rs_cnt_t;   // 0 to rs_int_depth
    typedef logic [$clog2(rs_int_depth)-1:0] rs_idx_t;
    typedef logic [$clog2(dispatch_rate):0]  slot_cnt_t; // 0 to dispatch_rate
    typedef logic [31:0]                     pc_t;
    typedef logic [11:0]                     imm_t;
    typedef logic [1:0]                      rs_type_t;

    // the only station kept in this stage
    localparam rs_type_t rs_type_int = 2'd0;

    //////////////////////////////////////////////////////////////////////
    // packed structs

    // renamed uop as delivered by rename
    typedef struct packed {
        logic     valid;
        rs_type_t rs_type;
        pc_t      pc;
        logic     reg_we;   // writes prd
        preg_t    prd;
        logic     is_rs1;   // prs1 is a real source
        preg_t    prs1;
        logic     is_rs2;
        preg_t    prs2;
        imm_t     imm;
    } uop_t;

    // integer station entry
    typedef struct packed {
        pc_t      pc;
        rob_idx_t rob_idx;
        logic     reg_we;
        preg_t    prd;
        preg_t    prs1;
        logic     prs1_rdy;
        preg_t    prs2;
        logic     prs2_rdy;
        imm_t     imm;
    } rs_entry_t;

    // one result broadcast from execution
    typedef struct packed {
        logic  valid;
        preg_t preg;
    } wakeup_t;

endpackage

// ==== src/dispatch_gate.sv ====
//////////////////////////////////////////////////////////////////////
// all-or-nothing dispatch decision for one rename group
// purely combinational; a flush blocks writes but not the stall
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module dispatch_gate import dispatch_pkg::*; (
    input  uop_t                          uops [dispatch_rate],
    input  logic      [dispatch_rate-1:0] rename_valid,
    input  logic                          flush,
    input  rs_cnt_t                       rs_free,
    input  rob_cnt_t                      rob_free,
    input  rob_idx_t  [dispatch_rate-1:0] rob_slot_idx,
    input  logic      [dispatch_rate-1:0][1:0] src_busy,  // [slot][prs2, prs1]
    output logic      [dispatch_rate-1:0] rs_wr_valid,
    output rs_entry_t [dispatch_rate-1:0] rs_wr_entry,
    output slot_cnt_t                     rob_alloc_cnt,
    output logic      [dispatch_rate-1:0] rob_alloc_mask,
    output logic      [dispatch_rate-1:0] set_busy_we,
    output logic                          rename_stall_request
);

    logic [dispatch_rate-1:0] live;     // slot carries a real uop
    logic [dispatch_rate-1:0] is_int;   // live and bound for the int station
    slot_cnt_t                uop_cnt;
    slot_cnt_t                int_cnt;
    logic                     rs_check;
    logic                     rob_check;
    logic                     free_check;
    logic                     dispatch_ok;

    //////////////////////////////////////////////////////////////////////
    // classify and count

    for (genvar g = 0; g < dispatch_rate; g++) begin : g_classify
        assign live[g]   = rename_valid[g] & uops[g].valid;
        assign is_int[g] = live[g] & (uops[g].rs_type == rs_type_int);
    end

    always_comb begin
        uop_cnt = '0;
        int_cnt = '0;
        for (int i = 0; i < dispatch_rate; i++) begin
            if (live[i]) begin
                uop_cnt = uop_cnt + 1'b1;
            end
            if (is_int[i]) begin
                int_cnt = int_cnt + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // free space checks

    assign rs_check  = rs_cnt_t'(int_cnt) <= rs_free;
    assign rob_check = rob_cnt_t'(uop_cnt) < rob_free;  // keep one ROB slot spare
    assign free_check = rs_check & rob_check;

    assign rename_stall_request = ~free_check;
    assign dispatch_ok          = free_check & ~flush;

    assign rob_alloc_cnt = dispatch_ok ? uop_cnt : '0;

    //////////////////////////////////////////////////////////////////////
    // per-slot writes and station entries

    for (genvar g = 0; g < dispatch_rate; g++) begin : g_entry
        assign rob_alloc_mask[g] = live[g] & dispatch_ok;
        assign rs_wr_valid[g]    = is_int[g] & dispatch_ok;
        assign set_busy_we[g]    = uops[g].reg_we & rob_alloc_mask[g];

        assign rs_wr_entry[g].pc       = uops[g].pc;
        assign rs_wr_entry[g].rob_idx  = rob_slot_idx[g];
        assign rs_wr_entry[g].reg_we   = uops[g].reg_we;
        assign rs_wr_entry[g].prd      = uops[g].prd;
        assign rs_wr_entry[g].prs1     = uops[g].prs1;
        assign rs_wr_entry[g].prs1_rdy = ~(uops[g].is_rs1 & src_busy[g][0]);
        assign rs_wr_entry[g].prs2     = uops[g].prs2;
        assign rs_wr_entry[g].prs2_rdy = ~(uops[g].is_rs2 & src_busy[g][1]);
        assign rs_wr_entry[g].imm      = uops[g].imm;
    end

endmodule

// ==== src/rob_counter.sv ====
//////////////////////////////////////////////////////////////////////
// ROB tail and occupancy only, no entry storage
// retire_cnt must not exceed the current occupancy
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rob_counter import dispatch_pkg::*; (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         flush,
    input  slot_cnt_t                    alloc_cnt,
    input  logic     [dispatch_rate-1:0] alloc_mask,
    input  slot_cnt_t                    retire_cnt,
    output rob_idx_t [dispatch_rate-1:0] slot_idx,
    output rob_cnt_t                     free_entries,
    output rob_cnt_t                     used_entries
);

    rob_idx_t tail_q;
    rob_cnt_t used_q;

    // each slot gets the tail plus the allocations below it
    always_comb begin
        rob_idx_t offset;
        offset = '0;
        for (int i = 0; i < dispatch_rate; i++) begin
            slot_idx[i] = tail_q + offset;   // wraps with the ROB
            if (alloc_mask[i]) begin
                offset = offset + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tail_q <= '0;
            used_q <= '0;
        end else if (flush) begin
            tail_q <= '0;
            used_q <= '0;
        end else begin
            tail_q <= tail_q + rob_idx_t'(alloc_cnt);
            used_q <= used_q + rob_cnt_t'(alloc_cnt) - rob_cnt_t'(retire_cnt);
        end
    end

    assign used_entries = used_q;
    assign free_entries = rob_cnt_t'(rob_depth) - used_q;

endmodule

// ==== src/busy_table.sv ====
//////////////////////////////////////////////////////////////////////
// one busy bit per physical register
// reads bypass the wakeup of the same cycle; a set beats a wakeup
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module busy_table import dispatch_pkg::*; (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         flush,
    input  logic  [dispatch_rate-1:0]    set_we,
    input  preg_t [dispatch_rate-1:0]    set_preg,
    input  wakeup_t                      wakeup,
    input  preg_t [2*dispatch_rate-1:0]  rd_preg,
    output logic  [2*dispatch_rate-1:0]  rd_busy
);

    logic [prf_depth-1:0] busy_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_q <= '0;
        end else if (flush) begin
            busy_q <= '0;
        end else begin
            if (wakeup.valid) begin
                busy_q[wakeup.preg] <= 1'b0;
            end
            // later assignment wins, so a new producer stays busy
            for (int i = 0; i < dispatch_rate; i++) begin
                if (set_we[i]) begin
                    busy_q[set_preg[i]] <= 1'b1;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read ports with wakeup bypass

    for (genvar g = 0; g < 2*dispatch_rate; g++) begin : g_read
        logic woken;
        assign woken      = wakeup.valid & (wakeup.preg == rd_preg[g]);
        assign rd_busy[g] = busy_q[rd_preg[g]] & ~woken;
    end

endmodule

// ==== src/int_rs.sv ====
//////////////////////////////////////////////////////////////////////
// eight-entry integer station, one issue request at a time
// a request is held until issued, even if an older entry gets ready
// writes assume free_entries was checked, extra writes are dropped
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module int_rs import dispatch_pkg::*; (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          flush,
    input  logic      [dispatch_rate-1:0] wr_valid,
    input  rs_entry_t [dispatch_rate-1:0] wr_entry,
    input  wakeup_t                       wakeup,
    input  logic                          issued,
    output rs_cnt_t                       free_entries,
    output logic                          issue_req_valid,
    output rs_entry_t                     issue_req_entry
);

    rs_entry_t [rs_int_depth-1:0]                    entry_q;
    logic      [rs_int_depth-1:0]                    vld_q;
    logic                                            hold_q;      // request pending
    rs_idx_t                                         hold_idx_q;
    logic      [dispatch_rate-1:0][rs_int_depth-1:0] grant;       // one-hot slot per write
    logic      [rs_int_depth-1:0]                    wr_mask;
    logic      [rs_int_depth-1:0]                    rdy;
    logic      [rs_int_depth-1:0]                    issue_clr;
    rs_idx_t                                         sel_idx;

    //////////////////////////////////////////////////////////////////////
    // free slot allocation, lowest free first

    always_comb begin
        logic [rs_int_depth-1:0] avail;
        avail   = ~vld_q;
        wr_mask = '0;
        for (int i = 0; i < dispatch_rate; i++) begin
            grant[i] = avail & (~avail + 1'b1);   // lowest set bit
            if (wr_valid[i]) begin
                wr_mask = wr_mask | grant[i];
                avail   = avail & ~grant[i];
            end
        end
    end

    always_comb begin
        free_entries = '0;
        for (int j = 0; j < rs_int_depth; j++) begin
            if (!vld_q[j]) begin
                free_entries = free_entries + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // oldest-ready select, lowest index wins

    for (genvar g = 0; g < rs_int_depth; g++) begin : g_rdy
        assign rdy[g] = vld_q[g] & entry_q[g].prs1_rdy & entry_q[g].prs2_rdy;
    end

    always_comb begin
        sel_idx         = '0;
        issue_req_valid = 1'b0;
        for (int j = rs_int_depth - 1; j >= 0; j--) begin
            if (rdy[j]) begin
                sel_idx         = rs_idx_t'(j);
                issue_req_valid = 1'b1;
            end
        end
        if (hold_q) begin
            sel_idx         = hold_idx_q;  // keep the pending request stable
            issue_req_valid = 1'b1;
        end
    end

    assign issue_req_entry = entry_q[sel_idx];

    always_comb begin
        issue_clr = '0;
        if (issue_req_valid && issued) begin
            issue_clr[sel_idx] = 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // entry payload and wakeup match

    always_ff @(posedge clk) begin
        for (int j = 0; j < rs_int_depth; j++) begin
            if (wakeup.valid && entry_q[j].prs1 == wakeup.preg) begin
                entry_q[j].prs1_rdy <= 1'b1;
            end
            if (wakeup.valid && entry_q[j].prs2 == wakeup.preg) begin
                entry_q[j].prs2_rdy <= 1'b1;
            end
            for (int i = 0; i < dispatch_rate; i++) begin
                if (wr_valid[i] && grant[i][j]) begin
                    entry_q[j] <= wr_entry[i];   // already sees this cycle's wakeup
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // valid bits and request hold

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vld_q      <= '0;
            hold_q     <= 1'b0;
            hold_idx_q <= '0;
        end else if (flush) begin
            vld_q      <= '0;
            hold_q     <= 1'b0;
            hold_idx_q <= '0;
        end else begin
            vld_q      <= (vld_q | wr_mask) & ~issue_clr;
            hold_q     <= issue_req_valid & ~issued;
            hold_idx_q <= sel_idx;
        end
    end

endmodule

// ==== src/dispatch_top.sv ====
//////////////////////////////////////////////////////////////////////
// integer dispatch path: gate, ROB counter, busy table, int station
// intra-group dependences are not detected, rename must avoid them
// the ROB only counts occupancy, no uop data is kept
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module dispatch_top import dispatch_pkg::*; (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     flush,
    input  uop_t                     uops [dispatch_rate],
    input  logic [dispatch_rate-1:0] rename_valid,
    input  wakeup_t                  wakeup,
    input  logic                     issued,
    input  slot_cnt_t                retire_cnt,
    output logic                     issue_req_valid,
    output rs_entry_t                issue_req_entry,
    output rob_cnt_t                 rob_used_entries,
    output logic                     rename_stall_request
);

    rs_cnt_t                          rs_free;
    rob_cnt_t                         rob_free;
    rob_idx_t  [dispatch_rate-1:0]    rob_slot_idx;
    slot_cnt_t                        rob_alloc_cnt;
    logic      [dispatch_rate-1:0]    rob_alloc_mask;
    logic      [dispatch_rate-1:0]    rs_wr_valid;
    rs_entry_t [dispatch_rate-1:0]    rs_wr_entry;
    logic      [dispatch_rate-1:0]    set_busy_we;
    preg_t     [dispatch_rate-1:0]    set_busy_preg;
    preg_t     [2*dispatch_rate-1:0]  src_preg;   // prs1, prs2 of each slot
    logic      [2*dispatch_rate-1:0]  src_busy;

    // busy table ports follow slot order
    for (genvar g = 0; g < dispatch_rate; g++) begin : g_slot_wires
        assign set_busy_preg[g]  = uops[g].prd;
        assign src_preg[2*g]     = uops[g].prs1;
        assign src_preg[2*g + 1] = uops[g].prs2;
    end

    dispatch_gate dispatch_gate_i (
        .uops                (uops),
        .rename_valid        (rename_valid),
        .flush               (flush),
        .rs_free             (rs_free),
        .rob_free            (rob_free),
        .rob_slot_idx        (rob_slot_idx),
        .src_busy            (src_busy),
        .rs_wr_valid         (rs_wr_valid),
        .rs_wr_entry         (rs_wr_entry),
        .rob_alloc_cnt       (rob_alloc_cnt),
        .rob_alloc_mask      (rob_alloc_mask),
        .set_busy_we         (set_busy_we),
        .rename_stall_request(rename_stall_request)
    );

    rob_counter rob_counter_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .flush       (flush),
        .alloc_cnt   (rob_alloc_cnt),
        .alloc_mask  (rob_alloc_mask),
        .retire_cnt  (retire_cnt),
        .slot_idx    (rob_slot_idx),
        .free_entries(rob_free),
        .used_entries(rob_used_entries)
    );

    busy_table busy_table_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .flush   (flush),
        .set_we  (set_busy_we),
        .set_preg(set_busy_preg),
        .wakeup  (wakeup),
        .rd_preg (src_preg),
        .rd_busy (src_busy)
    );

    int_rs int_rs_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .flush          (flush),
        .wr_valid       (rs_wr_valid),
        .wr_entry       (rs_wr_entry),
        .wakeup         (wakeup),
        .issued         (issued),
        .free_entries   (rs_free),
        .issue_req_valid(issue_req_valid),
        .issue_req_entry(issue_req_entry)
    );

endmodule

// ==== verification/dispatch_asserts.sv ====
//////////////////////////////////////////////////////////////////////
// port-level checks on dispatch_top, attached with bind
// expects retire_cnt to stay within the ROB occupancy
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module dispatch_asserts import dispatch_pkg::*; (
    input logic                     clk,
    input logic                     arst_n,
    input logic                     flush,
    input uop_t                     uops [dispatch_rate],
    input logic [dispatch_rate-1:0] rename_valid,
    input logic                     issued,
    input slot_cnt_t                retire_cnt,
    input logic                     issue_req_valid,
    input rs_entry_t                issue_req_entry,
    input rob_cnt_t                 rob_used_entries,
    input logic                     rename_stall_request
);

    int        err_cnt = 0;   // failed checks so far
    slot_cnt_t live_cnt;
    rob_cnt_t  exp_used_q;    // occupancy rebuilt from dispatch and retire

    always_comb begin
        live_cnt = '0;
        for (int i = 0; i < dispatch_rate; i++) begin
            if (rename_valid[i] && uops[i].valid) begin
                live_cnt = live_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exp_used_q <= '0;
        end else if (flush) begin
            exp_used_q <= '0;
        end else if (!rename_stall_request) begin
            exp_used_q <= exp_used_q + rob_cnt_t'(live_cnt) - rob_cnt_t'(retire_cnt);
        end else begin
            exp_used_q <= exp_used_q - rob_cnt_t'(retire_cnt);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // properties

    a_reset_idle: assert property (@(posedge clk) $rose(arst_n) |->
        !issue_req_valid && !rename_stall_request && rob_used_entries == 0)
        else begin
            $error("outputs not idle right after reset release");
            err_cnt++;
        end

    a_rob_used: assert property (@(posedge clk) disable iff (!arst_n)
        rob_used_entries == exp_used_q)
        else begin
            $error("MISMATCH rob_occupancy expected %0d actual %0d",
                   $sampled(exp_used_q), $sampled(rob_used_entries));
            err_cnt++;
        end

    a_rob_bound: assert property (@(posedge clk) disable iff (!arst_n)
        rob_used_entries <= rob_depth)
        else begin
            $error("MISMATCH rob_bound expected <= %0d actual %0d",
                   rob_depth, $sampled(rob_used_entries));
            err_cnt++;
        end

    a_rob_stall: assert property (@(posedge clk) disable iff (!arst_n)
        rob_used_entries + live_cnt >= rob_depth |-> rename_stall_request)
        else begin
            $error("no stall request although the ROB cannot take the group");
            err_cnt++;
        end

    // a pending request must not move until it is taken
    a_issue_hold: assert property (@(posedge clk) disable iff (!arst_n)
        issue_req_valid && !issued && !flush |=>
        issue_req_valid && $stable(issue_req_entry))
        else begin
            $error("issue request changed before issued was seen");
            err_cnt++;
        end

    a_flush_empty: assert property (@(posedge clk) disable iff (!arst_n)
        flush |=> !issue_req_valid && rob_used_entries == 0)
        else begin
            $error("station or ROB not empty in the cycle after a flush");
            err_cnt++;
        end

endmodule

// ==== verification/dispatch_tb.sv ====
//////////////////////////////////////////////////////////////////////
// random dispatch traffic with a busy-bit and pending-uop model
// the two slots of a group never depend on each other
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module dispatch_tb import dispatch_pkg::*; ();

    logic                     clk;
    logic                     arst_n;
    logic                     flush;
    uop_t                     uops [dispatch_rate];
    logic [dispatch_rate-1:0] rename_valid;
    wakeup_t                  wakeup;
    logic                     issued;
    slot_cnt_t                retire_cnt;
    logic                     issue_req_valid;
    rs_entry_t                issue_req_entry;
    rob_cnt_t                 rob_used_entries;
    logic                     rename_stall_request;

    integer               seed = 32'hc882b2be;
    logic [prf_depth-1:0] busy_m;   // busy bits as seen from the ports
    uop_t                 pend_q [$];   // integer uops dispatched, not yet issued
    rob_idx_t             pend_rob_q [$];   // ROB index handed to each pending uop
    rob_idx_t             tail_m;   // next ROB index to hand out
    int                   occ;
    pc_t                  next_pc;

    dispatch_top dispatch_top_i (.*);

    bind dispatch_top dispatch_asserts dispatch_asserts_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // helpers

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "stopped at first error");
    endtask

    function automatic bit rand_bit();
        return bit'($random(seed));
    endfunction

    function automatic bit reads_reg(input uop_t u, input preg_t r);
        return (u.is_rs1 && u.prs1 == r) || (u.is_rs2 && u.prs2 == r);
    endfunction

    // a new producer may not touch a live source or a busy register
    function automatic bit reg_ok(input preg_t r, input uop_t grp [dispatch_rate], input int s);
        if (busy_m[r]) begin
            return 1'b0;
        end
        for (int k = 0; k < dispatch_rate; k++) begin
            if (reads_reg(grp[k], r) || (k < s && grp[k].reg_we && grp[k].prd == r)) begin
                return 1'b0;
            end
        end
        foreach (pend_q[k]) begin
            if (reads_reg(pend_q[k], r)) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    function automatic preg_t pick_busy(input preg_t start);
        preg_t r;
        r = start;
        for (int i = 0; i < prf_depth; i++) begin
            if (busy_m[r]) begin
                return r;
            end
            r = r + 1'b1;
        end
        return start;
    endfunction

    task automatic drive_inputs(input bit fill, input bit drain);
        uop_t grp [dispatch_rate];
        int   rt;
        int   tries;
        for (int s = 0; s < dispatch_rate; s++) begin
            grp[s]         = '0;
            grp[s].valid   = fill | rand_bit();
            grp[s].rs_type = (fill || ($random(seed) & 3) == 0) ? rs_type_t'(2'd1) : rs_type_int;
            grp[s].pc      = next_pc;
            next_pc        = next_pc + 4;
            grp[s].is_rs1  = rand_bit();
            grp[s].prs1    = preg_t'($random(seed));
            grp[s].is_rs2  = rand_bit();
            grp[s].prs2    = preg_t'($random(seed));
            grp[s].imm     = imm_t'($random(seed));
        end
        for (int s = 0; s < dispatch_rate; s++) begin
            grp[s].reg_we = rand_bit();
            grp[s].prd    = preg_t'($random(seed));
            tries         = 0;
            while (grp[s].reg_we && !reg_ok(grp[s].prd, grp, s) && tries < 64) begin
                grp[s].prd = preg_t'($random(seed));
                tries++;
            end
            if (!reg_ok(grp[s].prd, grp, s)) begin
                grp[s].reg_we = 1'b0;   // no free register this time
            end
        end
        uops         = grp;
        rename_valid = drain ? '0 : (fill ? '1 : 2'($random(seed)));
        flush        = !fill && !drain && ($random(seed) & 31) == 0;
        issued       = drain | rand_bit();
        wakeup.valid = drain | rand_bit();
        wakeup.preg  = pick_busy(preg_t'($random(seed)));
        rt = fill ? 0 : (drain ? dispatch_rate : ($random(seed) & 3));
        if (rt > occ) begin
            rt = occ;
        end
        if (rt > dispatch_rate) begin
            rt = dispatch_rate;
        end
        retire_cnt = slot_cnt_t'(rt);
    endtask

    // applies what the coming clock edge does, judged from the ports
    task automatic update_model();
        int        idx;
        int        live_n;
        int        int_n;
        logic      exp_stall;
        uop_t      u;
        rs_entry_t exp_e;
        if (dispatch_top_i.dispatch_asserts_i.err_cnt != 0) begin
            fail_now("a concurrent assertion on the DUT ports failed");
        end
        live_n = 0;
        int_n  = 0;
        for (int s = 0; s < dispatch_rate; s++) begin
            if (rename_valid[s] && uops[s].valid) begin
                live_n++;
                if (uops[s].rs_type == rs_type_int) begin
                    int_n++;
                end
            end
        end
        // ROB needs a spare slot, the station only enough room
        exp_stall = (occ + live_n >= rob_depth) || (int_n > rs_int_depth - pend_q.size());
        if (rename_stall_request !== exp_stall) begin
            fail_now($sformatf("MISMATCH rename_stall expected %0b actual %0b",
                               exp_stall, rename_stall_request));
        end
        if (flush) begin
            busy_m = '0;
            pend_q.delete();
            pend_rob_q.delete();
            tail_m = '0;
            occ = 0;
        end else begin
            if (issue_req_valid && issued) begin
                idx = -1;
                foreach (pend_q[k]) begin
                    if (pend_q[k].pc == issue_req_entry.pc) begin
                        idx = k;
                    end
                end
                if (idx < 0) begin
                    fail_now($sformatf("issued pc %h matches no pending integer uop",
                                       issue_req_entry.pc));
                end else begin
                    u              = pend_q[idx];
                    exp_e          = '0;
                    exp_e.pc       = u.pc;
                    exp_e.rob_idx  = pend_rob_q[idx];
                    exp_e.reg_we   = u.reg_we;
                    exp_e.prd      = u.prd;
                    exp_e.prs1     = u.prs1;
                    exp_e.prs1_rdy = 1'b1;
                    exp_e.prs2     = u.prs2;
                    exp_e.prs2_rdy = 1'b1;
                    exp_e.imm      = u.imm;
                    if (issue_req_entry !== exp_e) begin
                        fail_now($sformatf("MISMATCH issue_entry expected %h actual %h",
                                           exp_e, issue_req_entry));
                    end
                    if (u.is_rs1 && busy_m[u.prs1]) begin
                        fail_now($sformatf("MISMATCH issue_src1_ready expected 0 actual %0b",
                                           issue_req_entry.prs1_rdy));
                    end
                    if (u.is_rs2 && busy_m[u.prs2]) begin
                        fail_now($sformatf("MISMATCH issue_src2_ready expected 0 actual %0b",
                                           issue_req_entry.prs2_rdy));
                    end
                    pend_q.delete(idx);
                    pend_rob_q.delete(idx);
                end
            end
            if (wakeup.valid) begin
                busy_m[wakeup.preg] = 1'b0;
            end
            for (int s = 0; s < dispatch_rate; s++) begin
                if (!rename_stall_request && rename_valid[s] && uops[s].valid) begin
                    if (uops[s].reg_we) begin
                        busy_m[uops[s].prd] = 1'b1;   // set beats wakeup
                    end
                    if (uops[s].rs_type == rs_type_int) begin
                        pend_q.push_back(uops[s]);
                        pend_rob_q.push_back(tail_m);
                    end
                    tail_m = tail_m + 1'b1;   // wraps with the ROB
                    occ++;
                end
            end
            occ = occ - int'(retire_cnt);
        end
    endtask

    task automatic step(input bit fill, input bit drain);
        @(negedge clk);
        drive_inputs(fill, drain);
        #10;   // outputs settled well before the rising edge
        update_model();
    endtask

    //////////////////////////////////////////////////////////////////////
    // test sequence

    initial begin
        int waited;
        arst_n       = 1'b0;
        flush        = 1'b0;
        uops         = '{default: '0};
        rename_valid = '0;
        wakeup       = '0;
        issued       = 1'b0;
        retire_cnt   = '0;
        busy_m       = '0;
        tail_m       = '0;
        occ          = 0;
        next_pc      = 32'h0000_1000;
        repeat (16) @(negedge clk);
        arst_n = 1'b1;

        repeat (400) step(1'b0, 1'b0);

        // no retirement until the ROB refuses a group
        waited = 0;
        do begin
            step(1'b1, 1'b0);
            waited++;
        end while (!rename_stall_request && waited < 64);
        if (!rename_stall_request) begin
            fail_now("ROB never filled up during the no-retire phase");
        end

        repeat (300) step(1'b0, 1'b0);

        waited = 0;
        do begin
            step(1'b0, 1'b1);
            waited++;
        end while ((pend_q.size() != 0 || occ != 0) && waited < 200);
        if (pend_q.size() != 0 || occ != 0) begin
            fail_now("station or ROB did not drain before the timeout");
        end

        @(negedge clk);
        if (dispatch_top_i.dispatch_asserts_i.err_cnt != 0) begin
            fail_now("a concurrent assertion on the DUT ports failed");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

// ==== filelist.f ====
src/dispatch_pkg.sv
src/dispatch_gate.sv
src/rob_counter.sv
src/busy_table.sv
src/int_rs.sv
src/dispatch_top.sv
verification/dispatch_asserts.sv
verification/dispatch_tb.sv
